/* design/fft_pkg.sv */
package fft_pkg;

    // ==========================================================================
    // Buffer geometry
    // ==========================================================================
    localparam int POINTS   = 16;               // Samples in the buffer
    localparam int ADDR_W   = $clog2(POINTS);
    localparam int SAMPLE_W = 16;

    typedef logic signed [SAMPLE_W-1:0] sample_t;    // One real sample
    typedef logic        [ADDR_W-1:0]   sample_addr_t;

    // One RAM access as presented by a peer
    typedef struct packed {
        logic         we;
        sample_addr_t addr;
        sample_t      wdata;
    } mem_req_t;

    // One command from the external host
    typedef struct packed {
        logic         write;
        sample_addr_t addr;
        sample_t      wdata;
    } host_xfer_t;

    // ==========================================================================
    // Arbiter masters and FSM states
    // ==========================================================================
    // Highest priority first
    typedef enum logic [1:0] {
        MST_BFLY,
        MST_AGEN,
        MST_HOST
    } master_e;

    typedef enum logic [2:0] {
        AG_IDLE,
        AG_READ_EVEN,
        AG_READ_ODD,
        AG_DRAIN,
        AG_DONE
    } agen_state_e;

    typedef enum logic [1:0] {
        HP_IDLE,
        HP_ACCESS,
        HP_WAIT_DATA,
        HP_ACK
    } hport_state_e;

endpackage

/* design/sample_ram.sv */
module sample_ram
    import fft_pkg::*;
(
    input  logic     clk,
    input  logic     en,
    input  mem_req_t req,
    output sample_t  rdata
);

    sample_t mem [POINTS];

    // Single port, so one access per cycle. Read word shows up one cycle later
    always_ff @(posedge clk) begin
        if (en) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rdata <= mem[req.addr];
            end
        end
    end

endmodule

/* design/ram_arbiter.sv */
module ram_arbiter
    import fft_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     bfly_req,
    input  logic     agen_req,
    input  logic     host_req,
    input  mem_req_t bfly_cmd,
    input  mem_req_t agen_cmd,
    input  mem_req_t host_cmd,
    output logic     bfly_gnt,
    output logic     agen_gnt,
    output logic     host_gnt,
    output logic     agen_rvalid,
    output logic     host_rvalid,
    output logic     ram_en,
    output mem_req_t ram_req
);

    master_e sel;
    logic    rd_pend_q;     // A read was granted last cycle
    master_e rd_mst_q;      // ... and this is who asked for it

    // Fixed priority: write-back, then generator reads, then host
    always_comb begin
        if (bfly_req) begin
            sel = MST_BFLY;
        end else if (agen_req) begin
            sel = MST_AGEN;
        end else begin
            sel = MST_HOST;
        end
    end

    assign ram_en   = bfly_req | agen_req | host_req;
    assign bfly_gnt = ram_en && (sel == MST_BFLY);
    assign agen_gnt = ram_en && (sel == MST_AGEN);
    assign host_gnt = ram_en && (sel == MST_HOST);

    always_comb begin
        case (sel)
            MST_BFLY: ram_req = bfly_cmd;
            MST_AGEN: ram_req = agen_cmd;
            default:  ram_req = host_cmd;
        endcase
    end

    // Steer read-data valid back to the reader, aligned with RAM rdata
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend_q <= 1'b0;
            rd_mst_q  <= MST_HOST;
        end else begin
            rd_pend_q <= ram_en && !ram_req.we;
            rd_mst_q  <= sel;
        end
    end

    assign agen_rvalid = rd_pend_q && (rd_mst_q == MST_AGEN);
    assign host_rvalid = rd_pend_q && (rd_mst_q == MST_HOST);

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({bfly_gnt, agen_gnt, host_gnt}));

endmodule

/* design/host_port.sv */
module host_port
    import fft_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       host_req,
    input  host_xfer_t host_cmd,
    output logic       host_ack,
    output sample_t    host_rdata,
    output logic       mem_req,
    output mem_req_t   mem_cmd,
    input  logic       mem_gnt,
    input  logic       mem_rvalid,
    input  sample_t    mem_rdata
);

    hport_state_e state, next_state;

    host_xfer_t cmd_q;      // Command held for the whole transfer
    sample_t    rdata_q;

    // ==========================================================================
    // Transfer FSM
    // ==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= HP_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            HP_IDLE: begin
                if (host_req) next_state = HP_ACCESS;
            end
            HP_ACCESS: begin
                if (mem_gnt) begin
                    next_state = cmd_q.write ? HP_ACK : HP_WAIT_DATA;
                end
            end
            HP_WAIT_DATA: begin
                if (mem_rvalid) next_state = HP_ACK;
            end
            HP_ACK: begin
                if (!host_req) next_state = HP_IDLE;    // Phase 3 seen, drop ack
            end
            default: next_state = HP_IDLE;
        endcase
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (state == HP_IDLE && host_req) begin
            cmd_q <= host_cmd;
        end
        if (state == HP_WAIT_DATA && mem_rvalid) begin
            rdata_q <= mem_rdata;
        end
    end

    assign mem_req       = (state == HP_ACCESS);
    assign mem_cmd.we    = cmd_q.write;
    assign mem_cmd.addr  = cmd_q.addr;
    assign mem_cmd.wdata = cmd_q.wdata;

    assign host_ack   = (state == HP_ACK);
    assign host_rdata = rdata_q;       // Valid while ack is high after a read

endmodule

/* design/pair_addr_gen.sv */
module pair_addr_gen
    import fft_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     run_req,
    output logic     run_ack,
    output logic     rd_req,
    output mem_req_t rd_cmd,
    input  logic     rd_gnt,
    input  logic     pass_written
);

    agen_state_e state, next_state;

    sample_addr_t rd_ptr;
    logic         last_rd;

    assign last_rd = (rd_ptr == sample_addr_t'(POINTS - 1));

    // ==========================================================================
    // Run FSM
    // ==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= AG_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            AG_IDLE: begin
                if (run_req) next_state = AG_READ_EVEN;
            end
            AG_READ_EVEN: begin
                if (rd_gnt) next_state = AG_READ_ODD;   // Stall in place otherwise
            end
            AG_READ_ODD: begin
                if (rd_gnt) begin
                    next_state = last_rd ? AG_DRAIN : AG_READ_EVEN;
                end
            end
            AG_DRAIN: begin
                // Wait for the butterfly to put back the last pair
                if (pass_written) next_state = AG_DONE;
            end
            AG_DONE: begin
                if (!run_req) next_state = AG_IDLE;
            end
            default: next_state = AG_IDLE;
        endcase
    end

    // Read pointer steps only on a granted read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (state == AG_IDLE) begin
            rd_ptr <= '0;
        end else if (rd_req && rd_gnt) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign rd_req       = (state == AG_READ_EVEN) || (state == AG_READ_ODD);
    assign rd_cmd.we    = 1'b0;
    assign rd_cmd.addr  = rd_ptr;
    assign rd_cmd.wdata = '0;

    assign run_ack = (state == AG_DONE);

    a_read_only: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req |-> !rd_cmd.we);

endmodule

/* design/stage1_butterfly.sv */
module stage1_butterfly
    import fft_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rd_valid,
    input  sample_t  rd_data,
    output logic     wr_req,
    output mem_req_t wr_cmd,
    input  logic     wr_gnt,
    output logic     pass_written
);

    sample_addr_t word_cnt;     // Words received this pass
    logic         wb_pend;      // Write-back of a pair in progress
    logic         wb_odd;       // Second word of the pair is next

    sample_t      even_q;
    sample_t      sum_q;
    sample_t      diff_q;
    sample_addr_t wb_addr;      // Even address of the pair being written

    logic signed [SAMPLE_W:0] sum_ext;
    logic signed [SAMPLE_W:0] diff_ext;
    logic                     odd_in;
    logic                     last_wr;

    // ==========================================================================
    // Butterfly with twiddle of one
    // ==========================================================================
    // One guard bit, then halve so the result always fits
    assign sum_ext  = {even_q[SAMPLE_W-1], even_q} + {rd_data[SAMPLE_W-1], rd_data};
    assign diff_ext = {even_q[SAMPLE_W-1], even_q} - {rd_data[SAMPLE_W-1], rd_data};

    assign odd_in  = rd_valid && word_cnt[0];
    assign last_wr = wr_gnt && wb_odd
                     && (wr_cmd.addr == sample_addr_t'(POINTS - 1));

    always_ff @(posedge clk) begin
        if (rd_valid && !word_cnt[0]) begin
            even_q <= rd_data;
        end
        if (odd_in) begin
            sum_q   <= sample_t'(sum_ext >>> 1);
            diff_q  <= sample_t'(diff_ext >>> 1);
            wb_addr <= {word_cnt[ADDR_W-1:1], 1'b0};
        end
    end

    // ==========================================================================
    // Word count and write-back control
    // ==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt     <= '0;
            wb_pend      <= 1'b0;
            wb_odd       <= 1'b0;
            pass_written <= 1'b0;
        end else begin
            pass_written <= last_wr;
            if (rd_valid) begin
                word_cnt <= word_cnt + 1'b1;
            end else if (last_wr) begin
                word_cnt <= '0;         // Ready for the next pass
            end

            if (odd_in) begin
                wb_pend <= 1'b1;
                wb_odd  <= 1'b0;
            end else if (wr_gnt) begin
                wb_odd <= ~wb_odd;
                if (wb_odd) wb_pend <= 1'b0;
            end
        end
    end

    assign wr_req       = wb_pend;
    assign wr_cmd.we    = 1'b1;
    assign wr_cmd.addr  = {wb_addr[ADDR_W-1:1], wb_odd};
    assign wr_cmd.wdata = wb_odd ? diff_q : sum_q;    // Sum to 2k, difference to 2k+1

    // Arbiter priority must drain a pair before the next one completes
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        odd_in |-> !wb_pend);

endmodule

/* design/fft_stage1_top.sv */
module fft_stage1_top
    import fft_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       host_req,
    input  host_xfer_t host_cmd,
    output logic       host_ack,
    output sample_t    host_rdata,
    input  logic       run_req,
    output logic       run_ack
);

    logic     bfly_req, agen_req, hp_req;
    mem_req_t bfly_cmd, agen_cmd, hp_cmd;
    logic     bfly_gnt, agen_gnt, hp_gnt;
    logic     agen_rvalid, hp_rvalid;
    logic     ram_en;
    mem_req_t ram_req;
    sample_t  ram_rdata;
    logic     pass_written;

    // ==========================================================================
    // Shared buffer and its arbiter
    // ==========================================================================
    sample_ram u_ram (
        .clk   (clk),
        .en    (ram_en),
        .req   (ram_req),
        .rdata (ram_rdata)
    );

    ram_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .bfly_req    (bfly_req),
        .agen_req    (agen_req),
        .host_req    (hp_req),
        .bfly_cmd    (bfly_cmd),
        .agen_cmd    (agen_cmd),
        .host_cmd    (hp_cmd),
        .bfly_gnt    (bfly_gnt),
        .agen_gnt    (agen_gnt),
        .host_gnt    (hp_gnt),
        .agen_rvalid (agen_rvalid),
        .host_rvalid (hp_rvalid),
        .ram_en      (ram_en),
        .ram_req     (ram_req)
    );

    // Peers
    host_port u_host (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .mem_req    (hp_req),
        .mem_cmd    (hp_cmd),
        .mem_gnt    (hp_gnt),
        .mem_rvalid (hp_rvalid),
        .mem_rdata  (ram_rdata)
    );

    pair_addr_gen u_agen (
        .clk          (clk),
        .rst_n        (rst_n),
        .run_req      (run_req),
        .run_ack      (run_ack),
        .rd_req       (agen_req),
        .rd_cmd       (agen_cmd),
        .rd_gnt       (agen_gnt),
        .pass_written (pass_written)
    );

    // Generator reads land straight in the butterfly
    stage1_butterfly u_bfly (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_valid     (agen_rvalid),
        .rd_data      (ram_rdata),
        .wr_req       (bfly_req),
        .wr_cmd       (bfly_cmd),
        .wr_gnt       (bfly_gnt),
        .pass_written (pass_written)
    );

endmodule

/* test/tb_fft_stage1.sv */
module tb_fft_stage1
    import fft_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic       clk;
    logic       rst_n;
    logic       host_req;
    host_xfer_t host_cmd;
    logic       host_ack;
    sample_t    host_rdata;
    logic       run_req;
    logic       run_ack;

    sample_t     model [POINTS];    // Expected buffer contents
    logic [15:0] lfsr_q;
    int          errors;
    int          checks;
    int          tests;
    int          err_mark;          // Error count when the current test began

    fft_stage1_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .run_req    (run_req),
        .run_ack    (run_ack)
    );

    always #2 clk = ~clk;           // 4 ns period

    // ==========================================================================
    // Helpers
    // ==========================================================================
    // Drive and sample 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic sample_t rand_sample();
        sample_t v;
        for (int b = 0; b < SAMPLE_W; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v[b]   = lfsr_q[0];
        end
        return v;
    endfunction

    // Full-scale pairs, then small values around zero
    function automatic sample_t extreme_value(input int i);
        case (i)
            0, 1, 4, 7, 13: extreme_value = 16'sh7FFF;
            2, 3, 5, 6, 15: extreme_value = 16'sh8000;
            8, 11, 14:      extreme_value = -16'sd1;
            default:        extreme_value = 16'sd1;
        endcase
    endfunction

    // Butterfly rule on the model: halved sum to 2k, halved difference to 2k+1
    task automatic model_pass();
        int a;
        int b;
        for (int k = 0; k < POINTS; k += 2) begin
            a = model[k];
            b = model[k + 1];
            model[k]     = sample_t'((a + b) >>> 1);
            model[k + 1] = sample_t'((a - b) >>> 1);
        end
    endtask

    task automatic compare_sample(input sample_t got, input sample_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %s: %s", name, (errors == err_mark) ? "ok" : "had errors");
        err_mark = errors;
    endtask

    // ==========================================================================
    // Handshakes
    // ==========================================================================
    task automatic host_xfer(input logic write, input sample_addr_t addr,
                             input sample_t wdata, output sample_t rdata);
        host_cmd = '{write: write, addr: addr, wdata: wdata};
        host_req = 1'b1;
        tick();
        compare_flag(host_ack, 1'b0, "host_ack not before the access");
        while (host_ack !== 1'b1) tick();
        rdata = host_rdata;
        tick();
        compare_flag(host_ack, 1'b1, "host_ack held while host_req high");
        host_req = 1'b0;
        while (host_ack !== 1'b0) tick();
    endtask

    task automatic host_write(input sample_addr_t addr, input sample_t data);
        sample_t unused;
        host_xfer(1'b1, addr, data, unused);
    endtask

    task automatic host_read(input sample_addr_t addr, output sample_t data);
        host_xfer(1'b0, addr, '0, data);
    endtask

    task automatic start_run();
        run_req = 1'b1;
        tick();
        compare_flag(run_ack, 1'b0, "run_ack low at start of pass");
    endtask

    task automatic finish_run();
        while (run_ack !== 1'b1) tick();
        tick();
        compare_flag(run_ack, 1'b1, "run_ack held while run_req high");
        run_req = 1'b0;
        while (run_ack !== 1'b0) tick();
    endtask

    task automatic run_pass();
        start_run();
        finish_run();
    endtask

    task automatic load_model();
        for (int i = 0; i < POINTS; i++) host_write(sample_addr_t'(i), model[i]);
    endtask

    task automatic check_model(input string what);
        sample_t d;
        for (int i = 0; i < POINTS; i++) begin
            host_read(sample_addr_t'(i), d);
            compare_sample(d, model[i], $sformatf("%s word %0d", what, i));
        end
    endtask

    // ==========================================================================
    // Directed tests
    // ==========================================================================
    initial begin
        sample_t d;
        clk      = 1'b0;
        rst_n    = 1'b0;
        host_req = 1'b0;
        host_cmd = '0;
        run_req  = 1'b0;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        err_mark = 0;
        lfsr_q   = 16'd8;

        // Acks stay low through reset and while idle
        repeat (8) begin
            tick();
            compare_flag(host_ack, 1'b0, "host_ack during reset");
            compare_flag(run_ack, 1'b0, "run_ack during reset");
        end
        rst_n = 1'b1;
        repeat (4) begin
            tick();
            compare_flag(host_ack, 1'b0, "host_ack idle after reset");
            compare_flag(run_ack, 1'b0, "run_ack idle after reset");
        end
        end_test("reset");

        foreach (model[i]) model[i] = rand_sample();
        load_model();
        check_model("loopback");
        end_test("loopback");

        foreach (model[i]) model[i] = sample_t'(i * 1000 - 7500);
        load_model();
        run_pass();
        model_pass();
        check_model("ramp");
        end_test("ramp");

        foreach (model[i]) model[i] = extreme_value(i);
        load_model();
        run_pass();
        model_pass();
        check_model("extremes");
        end_test("extremes");

        foreach (model[i]) model[i] = rand_sample();
        load_model();
        run_pass();
        run_pass();
        model_pass();
        model_pass();
        check_model("two passes");
        end_test("two_pass");

        // Host read waits behind the pass, pair 2 is written by then
        foreach (model[i]) model[i] = rand_sample();
        load_model();
        model_pass();
        start_run();
        host_read(sample_addr_t'(5), d);
        compare_sample(d, model[5], "read during pass");
        finish_run();
        check_model("after mid-pass read");
        end_test("mid_pass");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // 200 cycles per host transfer plus 400 per pass, over all tests
    initial begin
        int budget;
        budget = 8 + 200 * (5 * 2 * POINTS + 1) + 400 * 5;
        repeat (budget) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", budget);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* src.f */
design/fft_pkg.sv
design/sample_ram.sv
design/ram_arbiter.sv
design/host_port.sv
design/pair_addr_gen.sv
design/stage1_butterfly.sv
design/fft_stage1_top.sv
test/tb_fft_stage1.sv

/* Bender.yml */
package:
  name: fft_stage1

sources:
  - files:
      - design/fft_pkg.sv
      - design/sample_ram.sv
      - design/ram_arbiter.sv
      - design/host_port.sv
      - design/pair_addr_gen.sv
      - design/stage1_butterfly.sv
      - design/fft_stage1_top.sv
  - target: test
    files:
      - test/tb_fft_stage1.sv
